//--- hw/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module alu_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      go_i,
    input  exec_req_t req_i,
    output wb_t       wb_o
);

    logic                       we_q;
    logic [`REG_ADDR_WIDTH-1:0] rd_q;
    logic [`XLEN-1:0]           res_q;
    logic [`XLEN-1:0]           res;
    logic [4:0]                 shamt;

    assign shamt = req_i.b[4:0];

    always_comb begin
        case (req_i.info.alu.op)
            ALU_ADD:  res = req_i.a + req_i.b;
            ALU_SUB:  res = req_i.a - req_i.b;
            ALU_AND:  res = req_i.a & req_i.b;
            ALU_OR:   res = req_i.a | req_i.b;
            ALU_XOR:  res = req_i.a ^ req_i.b;
            ALU_SLL:  res = req_i.a << shamt;
            ALU_SRL:  res = req_i.a >> shamt;
            ALU_SRA:  res = $signed(req_i.a) >>> shamt;
            ALU_SLT:  res = {{(`XLEN-1){1'b0}}, $signed(req_i.a) < $signed(req_i.b)};
            ALU_SLTU: res = {{(`XLEN-1){1'b0}}, req_i.a < req_i.b};
            default:  res = '0;
        endcase
    end

    // one write strobe per accepted instruction
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            we_q <= 1'b0;
        end else begin
            we_q <= go_i;
        end
    end

    always_ff @(posedge clk) begin
        if (go_i) begin
            rd_q  <= req_i.rd;
            res_q <= res;
        end
    end

    assign wb_o = '{we: we_q, waddr: rd_q, wdata: res_q};

endmodule

`default_nettype wire

//--- hw/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath width
`define XLEN            32

// register file geometry
`define REG_ADDR_WIDTH  5
`define REG_NUM         32

// decode word layout
`define ALU_OP_WIDTH    4
`define DECINFO_WIDTH   5

// multiplier timing from start to result valid
`define MUL_CYCLES      4

// multiplier bits retired per cycle
`define MUL_RADIX_BITS  8

`endif

//--- hw/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

    typedef enum logic {
        GRP_ALU    = 1'b0,
        GRP_MULDIV = 1'b1
    } grp_e;

    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        MD_MUL    = 2'd0,
        MD_MULH   = 2'd1,
        MD_MULHSU = 2'd2,
        MD_MULHU  = 2'd3
    } muldiv_op_e;

    typedef struct packed {
        logic    imm_sel;
        alu_op_e op;
    } alu_info_t;

    typedef struct packed {
        logic [2:0] rsvd;
        muldiv_op_e op;
    } muldiv_info_t;

    // same decode word, view picked by grp
    typedef union packed {
        alu_info_t    alu;
        muldiv_info_t muldiv;
    } dec_info_u;

    typedef struct packed {
        grp_e                       grp;
        dec_info_u                  info;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`XLEN-1:0]           imm;
    } issue_t;

    typedef struct packed {
        logic [`XLEN-1:0]           a;
        logic [`XLEN-1:0]           b;
        dec_info_u                  info;
        logic [`REG_ADDR_WIDTH-1:0] rd;
    } exec_req_t;

    typedef struct packed {
        logic                       we;
        logic [`REG_ADDR_WIDTH-1:0] waddr;
        logic [`XLEN-1:0]           wdata;
    } wb_t;

endpackage

`default_nettype wire

//--- hw/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module exec_top import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   issue_valid_i,
    input  issue_t issue_i,
    output logic   stall_o,
    output wb_t    wb_o
);

    logic             alu_go;
    logic             mul_go;
    logic             mul_ready;
    logic             commit;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic             use_imm;
    exec_req_t        req;
    wb_t              alu_wb;
    wb_t              mul_wb;

    hdu u_hdu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .issue_valid_i(issue_valid_i),
        .issue_i      (issue_i),
        .commit_i     (commit),
        .stall_o      (stall_o),
        .alu_go_o     (alu_go),
        .mul_go_o     (mul_go)
    );

    regs u_regs (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (wb_o.we),
        .waddr_i (wb_o.waddr),
        .raddr1_i(issue_i.rs1),
        .raddr2_i(issue_i.rs2),
        .wdata_i (wb_o.wdata),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2)
    );

    // imm select only means something in the ALU view
    assign use_imm = (issue_i.grp == GRP_ALU) && issue_i.info.alu.imm_sel;

    assign req = '{a: rdata1, b: (use_imm ? issue_i.imm : rdata2),
                   info: issue_i.info, rd: issue_i.rd};

    alu_unit u_alu_unit (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .go_i   (alu_go),
        .req_i  (req),
        .wb_o   (alu_wb)
    );

    muldiv_unit u_muldiv_unit (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .go_i   (mul_go),
        .req_i  (req),
        .ready_i(mul_ready),
        .wb_o   (mul_wb)
    );

    wbu u_wbu (
        .alu_wb_i   (alu_wb),
        .mul_wb_i   (mul_wb),
        .mul_ready_o(mul_ready),
        .commit_o   (commit),
        .wb_o       (wb_o)
    );

endmodule

`default_nettype wire

//--- hw/hdu.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module hdu import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   issue_valid_i,
    input  issue_t issue_i,
    input  logic   commit_i,
    output logic   stall_o,
    output logic   alu_go_o,
    output logic   mul_go_o
);

    logic                       pend_q;
    logic [`REG_ADDR_WIDTH-1:0] pend_rd_q;
    logic                       is_mul;
    logic                       hit;
    logic                       accept;

    assign is_mul = (issue_i.grp == GRP_MULDIV);

    // RAW on either source or WAW on rd against the outstanding multiply
    assign hit = (issue_i.rs1 == pend_rd_q) || (issue_i.rs2 == pend_rd_q) ||
                 (issue_i.rd == pend_rd_q);

    // a commit this cycle frees the slot, and its value is bypassed by regs
    assign stall_o = pend_q && !commit_i && (hit || is_mul);

    assign accept   = issue_valid_i && !stall_o;
    assign alu_go_o = accept && !is_mul;
    assign mul_go_o = accept && is_mul;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pend_q <= 1'b0;
        end else if (mul_go_o) begin
            pend_q <= 1'b1;
        end else if (commit_i) begin
            pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_go_o) begin
            pend_rd_q <= issue_i.rd;
        end
    end

endmodule

`default_nettype wire

//--- hw/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module muldiv_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      go_i,
    input  exec_req_t req_i,
    input  logic      ready_i,
    output wb_t       wb_o
);

    localparam int CNT_W = $clog2(`MUL_CYCLES) + 1;

    logic                       busy_q;
    logic                       done_q;
    logic [CNT_W-1:0]           cnt_q;
    logic [2*`XLEN-1:0]         mcand_q;
    logic [`XLEN-1:0]           mplier_q;
    logic [2*`XLEN-1:0]         acc_q;
    logic                       neg_q;
    logic                       hi_q;
    logic [`REG_ADDR_WIDTH-1:0] rd_q;
    muldiv_op_e                 op;
    logic                       a_neg;
    logic                       b_neg;
    logic [2*`XLEN-1:0]         prod;

    assign op = req_i.info.muldiv.op;

    // mulh treats both operands as signed, mulhsu only the first
    assign a_neg = ((op == MD_MULH) || (op == MD_MULHSU)) && req_i.a[`XLEN-1];
    assign b_neg = (op == MD_MULH) && req_i.b[`XLEN-1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (go_i) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(`MUL_CYCLES - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
            // result stays until wbu takes it
            if (done_q && ready_i) begin
                done_q <= 1'b0;
            end
        end
    end

    // magnitudes in, one radix digit of the multiplier per cycle
    always_ff @(posedge clk) begin
        if (go_i) begin
            mcand_q  <= {{`XLEN{1'b0}}, (a_neg ? -req_i.a : req_i.a)};
            mplier_q <= b_neg ? -req_i.b : req_i.b;
            acc_q    <= '0;
            neg_q    <= a_neg ^ b_neg;
            hi_q     <= (op != MD_MUL);
            rd_q     <= req_i.rd;
        end else if (busy_q) begin
            acc_q    <= acc_q + mcand_q * mplier_q[`MUL_RADIX_BITS-1:0];
            mcand_q  <= mcand_q << `MUL_RADIX_BITS;
            mplier_q <= mplier_q >> `MUL_RADIX_BITS;
        end
    end

    // sign restored on the way out
    assign prod = neg_q ? -acc_q : acc_q;

    assign wb_o = '{we: done_q, waddr: rd_q,
                    wdata: (hi_q ? prod[2*`XLEN-1:`XLEN] : prod[`XLEN-1:0])};

endmodule

`default_nettype wire

//--- hw/regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module regs (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       we_i,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2_i,
    input  logic [`XLEN-1:0]           wdata_i,
    output logic [`XLEN-1:0]           rdata1_o,
    output logic [`XLEN-1:0]           rdata2_o
);

    logic [`XLEN-1:0] rf_q [`REG_NUM];

    // x0 never gets written
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                rf_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            rf_q[waddr_i] <= wdata_i;
        end
    end

    // write-first bypass so a committing result is seen in the same cycle
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && (waddr_i == raddr1_i)) ? wdata_i : rf_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && (waddr_i == raddr2_i)) ? wdata_i : rf_q[raddr2_i];

endmodule

`default_nettype wire

//--- hw/wbu.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module wbu import core_pkg::*; (
    input  wb_t  alu_wb_i,
    input  wb_t  mul_wb_i,
    output logic mul_ready_o,
    output logic commit_o,
    output wb_t  wb_o
);

    logic mul_sel;

    // ALU never waits, so the multiply only gets the free slots
    assign mul_sel = mul_wb_i.we && !alu_wb_i.we;

    assign mul_ready_o = mul_sel;

    // the only long instruction retires here
    assign commit_o = mul_sel;

    always_comb begin
        if (alu_wb_i.we) begin
            wb_o = alu_wb_i;
        end else if (mul_sel) begin
            wb_o = mul_wb_i;
        end else begin
            wb_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tb_exec_top
    import core_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int N_INSTR        = 300;
    localparam int TIMEOUT_CYCLES = N_INSTR * (`MUL_CYCLES + 3) + 100;

    logic   clk;
    logic   rst_n_i;
    logic   issue_valid_i;
    issue_t issue_i;
    logic   stall_o;
    wb_t    wb_o;

    // reference state
    logic [`XLEN-1:0]           mregs [`REG_NUM];
    wb_t                        alu_exp = '0;
    logic                       mul_busy = 1'b0;
    logic [`REG_ADDR_WIDTH-1:0] mul_rd = '0;
    logic [`XLEN-1:0]           mul_val = '0;
    int                         mul_ready_t = 0;

    // stimulus state
    logic [31:0] lfsr_q = 32'd83;
    issue_t      cur = '0;
    logic        have_cur = 1'b0;
    logic        cur_valid = 1'b0;
    int          n_issued = 0;
    int          cyc_idx = 0;
    int          tick_cnt = 0;

    exec_top UUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .issue_valid_i(issue_valid_i),
        .issue_i      (issue_i),
        .stall_o      (stall_o),
        .wb_o         (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        tick_cnt = tick_cnt + 1;
        if (tick_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: instructions did not drain");
            $display("STATUS: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [`XLEN-1:0] alu_model(input alu_op_e op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        logic [4:0]       sh;
        logic [`XLEN-1:0] fill;
        sh   = b[4:0];
        fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 1'b1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | fill;
            // signed compare by flipping the sign bits
            ALU_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] mul_model(input muldiv_op_e op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        logic [63:0] ax;
        logic [63:0] bx;
        logic [63:0] p;
        ax = {32'b0, a};
        bx = {32'b0, b};
        if ((op == MD_MULH) || (op == MD_MULHSU)) begin
            ax = {{32{a[31]}}, a};
        end
        if (op == MD_MULH) begin
            bx = {{32{b[31]}}, b};
        end
        p = ax * bx;
        return (op == MD_MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got !== exp) begin
            $display("ERROR: wb_o got we=%h waddr=%h wdata=%h, expected we=%h waddr=%h wdata=%h",
                     got.we, got.waddr, got.wdata, exp.we, exp.waddr, exp.wdata);
            $display("STATUS: FAIL");
            $fatal(1, "write port mismatch");
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR: stall_o got %h, expected %h", got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "stall mismatch");
        end
    endtask

    // registers from 0..7 so hazards come often
    task automatic gen_instr(output issue_t ins);
        ins = '0;
        if (rand_bits(2) == 32'd0) begin
            ins.grp            = GRP_MULDIV;
            ins.info.muldiv.op = muldiv_op_e'(rand_bits(2));
        end else begin
            ins.grp              = GRP_ALU;
            ins.info.alu.imm_sel = rand_bits(1) != 32'd0;
            ins.info.alu.op      = alu_op_e'(rand_bits(4) % 10);
        end
        ins.rd  = 5'(rand_bits(3));
        ins.rs1 = 5'(rand_bits(3));
        ins.rs2 = 5'(rand_bits(3));
        ins.imm = rand_bits(32);
    endtask

    // one clock per call, driven on the falling edge and sampled a quarter period later
    task automatic run_cycle();
        wb_t              exp_wb;
        logic             exp_stall;
        logic             commit;
        logic             hit;
        logic [`XLEN-1:0] opa;
        logic [`XLEN-1:0] opb;
        @(negedge clk);
        if (!have_cur && (n_issued < N_INSTR) && (cyc_idx >= 2)) begin
            gen_instr(cur);
            have_cur  = 1'b1;
            cur_valid = 1'b0;
        end
        // once raised, valid stays up until accepted
        if (have_cur && !cur_valid) begin
            cur_valid = rand_bits(2) != 32'd0;
        end
        issue_valid_i = cur_valid;
        issue_i       = cur;
        #(CLK_PERIOD / 4);

        // ALU write wins, multiply takes the first free slot
        exp_wb = '0;
        commit = 1'b0;
        if (alu_exp.we) begin
            exp_wb = alu_exp;
        end else if (mul_busy && (cyc_idx >= mul_ready_t)) begin
            exp_wb = '{we: 1'b1, waddr: mul_rd, wdata: mul_val};
            commit = 1'b1;
        end
        check_wb(wb_o, exp_wb);

        hit = (cur.rs1 == mul_rd) || (cur.rs2 == mul_rd) || (cur.rd == mul_rd);
        exp_stall = mul_busy && !commit && (hit || (cur.grp == GRP_MULDIV));
        check_stall(stall_o, exp_stall);

        if (commit) begin
            mul_busy = 1'b0;
        end
        alu_exp = '0;
        if (cur_valid && !exp_stall) begin
            opa = mregs[cur.rs1];
            opb = ((cur.grp == GRP_ALU) && cur.info.alu.imm_sel) ? cur.imm : mregs[cur.rs2];
            if (cur.grp == GRP_ALU) begin
                alu_exp = '{we: 1'b1, waddr: cur.rd, wdata: alu_model(cur.info.alu.op, opa, opb)};
                if (cur.rd != '0) begin
                    mregs[cur.rd] = alu_exp.wdata;
                end
            end else begin
                mul_busy    = 1'b1;
                mul_rd      = cur.rd;
                mul_val     = mul_model(cur.info.muldiv.op, opa, opb);
                mul_ready_t = cyc_idx + `MUL_CYCLES + 1;
                if (cur.rd != '0) begin
                    mregs[cur.rd] = mul_val;
                end
            end
            have_cur  = 1'b0;
            cur_valid = 1'b0;
            n_issued  = n_issued + 1;
        end
        cyc_idx = cyc_idx + 1;
    endtask

    initial begin
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        for (int i = 0; i < `REG_NUM; i++) begin
            mregs[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;

        while ((n_issued < N_INSTR) || alu_exp.we || mul_busy) begin
            run_cycle();
        end
        // idle tail where the port must stay quiet
        repeat (3) run_cycle();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/core_pkg.sv
hw/regs.sv
hw/alu_unit.sv
hw/muldiv_unit.sv
hw/hdu.sv
hw/wbu.sv
hw/exec_top.sv
sim/tb_exec_top.sv
